// ==== files.f ====
rs_ops_pkg.sv
rs_types_pkg.sv
rs_entry.sv
rs_station.sv
alu_pipe.sv
rs_top.sv
tb_rs_top.sv

// ==== Makefile ====
# Verilator build and run for the reservation station testbench

VERILATOR ?= verilator
TOP       ?= tb_rs_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Done: no errors

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, not the simulator exit code
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_rs_top.sv ====
`timescale 1ns/1ps

module tb_rs_top;
    import rs_types_pkg::*;
    import rs_ops_pkg::*;

    localparam int RS_DEPTH   = 4;
    localparam int N_TAGS     = 1 << TAG_W;
    localparam int WAIT_LIMIT = 200;  // cycles per wait loop
    localparam int SETTLE     = 12;   // quiet window to catch late or repeated broadcasts
    localparam int REL_TAG    = 14;   // produced only by the release row
    localparam int T_READY    = 0;
    localparam int T_CHAIN    = 1;
    localparam int T_SAME     = 2;
    localparam int T_FULL     = 3;
    localparam int T_SQUASH   = 4;
    localparam int T_RANDOM   = 5;
    localparam int N_TESTS    = 6;

    // one instruction of the stimulus table
    typedef struct packed {
        int       test;
        alu_op_e  op;
        logic     w1;    // src1 waits on t1
        tag_idx_t t1;
        word_t    v1;
        logic     w2;
        tag_idx_t t2;
        word_t    v2;
        tag_idx_t dest;
        int       gap;   // dispatch edges to the next row (2 or more)
        int       lat;   // expected dispatch to cdb cycles where 0 skips the check
        logic     kill;  // squashed so it must never broadcast
        logic     sq;    // squash pulse right after this row
    } row_t;

    logic   clock = 1'b0;
    logic   arst_n;
    logic   squash;
    logic   disp_valid;
    disp_t  disp_pkt;
    logic   full;
    logic   issue_fire;
    cdb_t   cdb;

    row_t   rows [$];
    string  test_names [N_TESTS] = '{"ready_operands", "dep_chain", "same_cycle",
                                     "full_station", "squash", "random"};
    int     seen_cnt  [N_TAGS];  // broadcasts per tag in the current test
    word_t  seen_val  [N_TAGS];
    int     cdb_cyc   [N_TAGS];  // cycle the broadcast was on the bus
    int     disp_edge [N_TAGS];  // edge that took the dispatch
    word_t  exp_val   [N_TAGS];  // reference result per tag
    int     cycle      = 0;
    int     errors     = 0;
    int     checks     = 0;
    int     test_err   = 0;
    int     broadcasts = 0;
    int     fires      = 0;      // cycles with issue_fire high
    logic   full_seen  = 1'b0;

    always #10 clock = ~clock;  // 20 ns period

    always @(posedge clock) cycle <= cycle + 1;

    rs_top #(
        .RS_DEPTH (RS_DEPTH)
    ) DUT (
        .clock      (clock),
        .arst_n     (arst_n),
        .squash     (squash),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .full       (full),
        .issue_fire (issue_fire),
        .cdb        (cdb)
    );

    // bus monitor samples mid-cycle where everything is settled
    always @(negedge clock) begin
        if (arst_n) begin
            if (cdb.valid) begin
                seen_cnt[cdb.tag] = seen_cnt[cdb.tag] + 1;
                seen_val[cdb.tag] = cdb.value;
                cdb_cyc[cdb.tag]  = cycle;
                broadcasts        = broadcasts + 1;
            end
            if (issue_fire) begin
                fires = fires + 1;
            end
            if (disp_valid) begin
                disp_edge[disp_pkt.dest] = cycle + 1;  // taken at the coming edge
            end
            if (full) begin
                full_seen = 1'b1;
            end
        end
    end

    function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
        word_t r;
        int    sh;
        sh = int'(b[4:0]);  // shift amount is the low five bits
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a + ~b + 32'd1;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = a >> sh;
            // a negative a is less when signs differ and magnitude order decides otherwise
            default: r = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
        endcase
        return r;
    endfunction

    task automatic add_row(int test, alu_op_e op, logic w1, word_t a, logic w2, word_t b,
                           int dest, int gap, int lat, logic kill, logic sq);
        row_t r;
        r.test = test;
        r.op   = op;
        r.w1   = w1;
        r.t1   = a[TAG_W-1:0];
        r.v1   = w1 ? 32'hdead_beef : a;  // junk while the tag is valid
        r.w2   = w2;
        r.t2   = b[TAG_W-1:0];
        r.v2   = w2 ? 32'hdead_beef : b;
        r.dest = tag_idx_t'(dest);
        r.gap  = gap;
        r.lat  = lat;
        r.kill = kill;
        r.sq   = sq;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(T_READY, OP_ADD, 0, 32'h1234_5678, 0, 32'h0fed_cba9, 1, 4, 3, 0, 0);
        // producer with a consumer on both operands and a second link
        add_row(T_CHAIN, OP_SUB, 0, 32'd1000, 0, 32'd58, 0, 2, 3, 0, 0);
        add_row(T_CHAIN, OP_ADD, 1, 32'd0, 1, 32'd0, 1, 2, 0, 0, 0);
        add_row(T_CHAIN, OP_SLL, 0, 32'h0000_00ff, 1, 32'd1, 2, 2, 0, 0, 0);
        // gap 4 lands the consumer's dispatch on the producer's broadcast cycle
        add_row(T_SAME, OP_OR, 0, 32'hf0f0_0000, 0, 32'h0000_0f0f, 2, 4, 3, 0, 0);
        add_row(T_SAME, OP_AND, 1, 32'd2, 0, 32'hff00_ff00, 3, 2, 3, 0, 0);
        for (int i = 0; i < RS_DEPTH - 1; i++) begin
            add_row(T_FULL, alu_op_e'(3'(i)), 1, REL_TAG, 0, 32'h10 + i, 4 + i, 2, 0, 0, 0);
        end
        add_row(T_FULL, OP_XOR, 0, 32'h8000_1234, 0, 32'h0000_4321, REL_TAG, 2, 0, 0, 0);
        add_row(T_SQUASH, OP_ADD, 1, 32'd10, 0, 32'd5, 8, 2, 0, 1, 0);  // parked on tag 10
        add_row(T_SQUASH, OP_SUB, 0, 32'd77, 0, 32'd7, 9, 2, 0, 1, 1);   // in the pipe
        add_row(T_SQUASH, OP_ADD, 0, 32'd300, 0, 32'd45, 10, 2, 3, 0, 0);
        for (int i = 0; i < N_TAGS; i++) begin  // each opcode twice and each tag once
            add_row(T_RANDOM, alu_op_e'(3'(i)), 0, $urandom(), 0, $urandom(), i, 2, 0, 0, 0);
        end
    endtask

    task automatic compare_value(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic dispatch_row(row_t r);
        disp_t pkt;
        int    n;
        n = 0;
        @(negedge clock);
        while (full && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (full) begin
            $display("dispatch of tag %0d abandoned, the station stayed full", r.dest);
            errors++;
            test_err++;
        end else begin
            pkt.op         = r.op;
            pkt.tag1.valid = r.w1;
            pkt.tag1.idx   = r.t1;
            pkt.tag2.valid = r.w2;
            pkt.tag2.idx   = r.t2;
            pkt.src1       = r.v1;
            pkt.src2       = r.v2;
            pkt.dest       = r.dest;
            @(posedge clock);
            disp_valid <= 1'b1;
            disp_pkt   <= pkt;
            @(posedge clock);  // dispatch edge
            disp_valid <= 1'b0;
            repeat (r.gap - 2) @(posedge clock);
        end
    endtask

    task automatic pulse_squash();
        @(posedge clock);
        squash <= 1'b1;
        @(posedge clock);
        squash <= 1'b0;
    endtask

    task automatic wait_broadcasts(int id);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clock);
            n++;
            done = 1'b1;
            foreach (rows[i]) begin
                if (rows[i].test == id && !rows[i].kill && seen_cnt[rows[i].dest] == 0) begin
                    done = 1'b0;
                end
            end
        end
        if (!done) begin
            $display("test %s timed out waiting for its broadcasts", test_names[id]);
            errors++;
            test_err++;
        end
        repeat (SETTLE) @(posedge clock);
    endtask

    // fixed point over the test's rows lets later producers resolve earlier consumers
    task automatic compute_expected(int id);
        word_t a;
        word_t b;
        for (int p = 0; p < rows.size(); p++) begin
            foreach (rows[i]) begin
                if (rows[i].test == id && !rows[i].kill) begin
                    a = rows[i].w1 ? exp_val[rows[i].t1] : rows[i].v1;
                    b = rows[i].w2 ? exp_val[rows[i].t2] : rows[i].v2;
                    exp_val[rows[i].dest] = alu_model(rows[i].op, a, b);
                end
            end
        end
    endtask

    task automatic check_rows(int id, int bcast_start, int fire_start);
        int   live;
        int   issued;
        row_t r;
        live   = 0;
        issued = 0;
        foreach (rows[i]) begin
            r = rows[i];
            if (r.test != id) begin
                continue;
            end
            if (r.kill) begin
                compare_value($sformatf("broadcasts of tag %0d", r.dest),
                              word_t'(seen_cnt[r.dest]), 32'd0);
                if (!r.w1 && !r.w2) begin  // ready on dispatch so it issued before the squash
                    issued++;
                end
                continue;
            end
            live++;
            issued++;
            compare_value($sformatf("broadcasts of tag %0d", r.dest),
                          word_t'(seen_cnt[r.dest]), 32'd1);
            compare_value($sformatf("cdb.value of tag %0d", r.dest),
                          seen_val[r.dest], exp_val[r.dest]);
            if (r.lat != 0) begin
                compare_value($sformatf("latency of tag %0d", r.dest),
                              word_t'(cdb_cyc[r.dest] - disp_edge[r.dest]), word_t'(r.lat));
            end
            if (r.w1) begin  // consumer broadcasts after its producer
                compare_value($sformatf("wake order of tag %0d", r.dest),
                              word_t'(cdb_cyc[r.dest] > cdb_cyc[r.t1]), 32'd1);
            end
            if (r.w2) begin
                compare_value($sformatf("wake order of tag %0d", r.dest),
                              word_t'(cdb_cyc[r.dest] > cdb_cyc[r.t2]), 32'd1);
            end
        end
        compare_value("cdb broadcasts in test", word_t'(broadcasts - bcast_start), word_t'(live));
        compare_value("issue_fire cycles in test", word_t'(fires - fire_start), word_t'(issued));
    endtask

    task automatic run_test(int id);
        int bcast_start;
        int fire_start;
        test_err    = 0;
        full_seen   = 1'b0;
        bcast_start = broadcasts;
        fire_start  = fires;
        for (int t = 0; t < N_TAGS; t++) begin
            seen_cnt[t] = 0;
        end
        foreach (rows[i]) begin
            if (rows[i].test == id) begin
                dispatch_row(rows[i]);
                if (rows[i].sq) begin
                    pulse_squash();
                end
            end
        end
        wait_broadcasts(id);
        compute_expected(id);
        check_rows(id, bcast_start, fire_start);
        if (id == T_FULL) begin
            compare_value("full seen high", word_t'(full_seen), 32'd1);
            compare_value("full", word_t'(full), 32'd0);  // drained again
        end
        $display("test %-14s %s, %0d errors", test_names[id],
                 (test_err == 0) ? "ok" : "failed", test_err);
    endtask

    initial begin
        void'($urandom(37132));
        arst_n     = 1'b0;
        squash     = 1'b0;
        disp_valid = 1'b0;
        disp_pkt   = '0;
        build_table();
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
        @(posedge clock);
        for (int id = 0; id < N_TESTS; id++) begin
            run_test(id);
        end
        $display("tests %0d, checks %0d, errors %0d, broadcasts %0d",
                 N_TESTS, checks, errors, broadcasts);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== rs_top.sv ====
`timescale 1ns/1ps

module rs_top #(
    parameter int RS_DEPTH = 4   // station entries, 2 or more
) (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                squash,
    input  logic                disp_valid,
    input  rs_types_pkg::disp_t disp_pkt,
    output logic                full,
    output logic                issue_fire,
    output rs_types_pkg::cdb_t  cdb        // also fed back for wake-up
);
    import rs_types_pkg::*;

    logic   issue_valid;
    issue_t issue_pkt;

    rs_station #(
        .RS_DEPTH (RS_DEPTH)
    ) u_station (
        .clock       (clock),
        .arst_n      (arst_n),
        .squash      (squash),
        .disp_valid  (disp_valid),
        .disp_pkt    (disp_pkt),
        .cdb         (cdb),
        .full        (full),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt)
    );

    alu_pipe u_alu (
        .clock       (clock),
        .arst_n      (arst_n),
        .squash      (squash),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .cdb         (cdb)
    );

    assign issue_fire = issue_valid;  // issue register output, already a flop

endmodule

// ==== alu_pipe.sv ====
`timescale 1ns/1ps

module alu_pipe (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 squash,
    input  logic                 issue_valid,
    input  rs_types_pkg::issue_t issue_pkt,
    output rs_types_pkg::cdb_t   cdb
);
    import rs_types_pkg::*;
    import rs_ops_pkg::*;

    // stage 1, operands
    logic     s1_valid;
    alu_op_e  s1_op;
    word_t    s1_a;
    word_t    s1_b;
    tag_idx_t s1_dest;
    word_t    result;

    // stage 2, broadcast register
    logic     cdb_valid_q;
    tag_idx_t cdb_tag_q;
    word_t    cdb_value_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid    <= 1'b0;
            cdb_valid_q <= 1'b0;
        end else if (squash) begin
            s1_valid    <= 1'b0;  // nothing in flight survives
            cdb_valid_q <= 1'b0;
        end else begin
            s1_valid    <= issue_valid;
            cdb_valid_q <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            s1_op   <= issue_pkt.op;
            s1_a    <= issue_pkt.src1;
            s1_b    <= issue_pkt.src2;
            s1_dest <= issue_pkt.dest;
        end
        if (s1_valid) begin
            cdb_tag_q   <= s1_dest;
            cdb_value_q <= result;
        end
    end

    always_comb begin
        case (s1_op)
            OP_ADD:  result = s1_a + s1_b;
            OP_SUB:  result = s1_a - s1_b;
            OP_AND:  result = s1_a & s1_b;
            OP_OR:   result = s1_a | s1_b;
            OP_XOR:  result = s1_a ^ s1_b;
            OP_SLL:  result = s1_a << s1_b[SHAMT_W-1:0];
            OP_SRL:  result = s1_a >> s1_b[SHAMT_W-1:0];
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(s1_a) < $signed(s1_b)};
            default: result = '0;
        endcase
    end

    assign cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};

    // operands entering the pipe were fully resolved in the station
    a_cdb_known: assert property (@(posedge clock) disable iff (!arst_n)
        cdb.valid |-> !$isunknown(cdb))
        else $error("alu_pipe: unknown bits on valid cdb");

endmodule

// ==== rs_station.sv ====
`timescale 1ns/1ps

module rs_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 squash,
    input  logic                 disp_valid,  // single-cycle strobe without back-pressure
    input  rs_types_pkg::disp_t  disp_pkt,
    input  rs_types_pkg::cdb_t   cdb,
    output logic                 full,
    output logic                 issue_valid,
    output rs_types_pkg::issue_t issue_pkt
);
    import rs_types_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] busy_vec;
    logic [RS_DEPTH-1:0] ready_vec;
    logic [RS_DEPTH-1:0] wr_en_vec;
    logic [RS_DEPTH-1:0] clear_vec;
    fwd_e                fwd   [RS_DEPTH];
    issue_t              slot  [RS_DEPTH];

    logic [IDX_W-1:0] alloc_idx;   // lowest free slot
    logic [IDX_W-1:0] rr_ptr;      // round-robin start point
    logic [IDX_W-1:0] pick_idx;
    logic             pick_valid;
    issue_t           sel_pkt;     // picked slot with cdb values patched in

    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        assign wr_en_vec[i] = disp_valid && !full && (alloc_idx == IDX_W'(i));
        assign clear_vec[i] = pick_valid && (pick_idx == IDX_W'(i));

        rs_entry u_entry (
            .clock    (clock),
            .arst_n   (arst_n),
            .squash   (squash),
            .wr_en    (wr_en_vec[i]),
            .clear    (clear_vec[i]),
            .disp_pkt (disp_pkt),
            .cdb      (cdb),
            .busy     (busy_vec[i]),
            .ready    (ready_vec[i]),
            .fwd      (fwd[i]),
            .slot     (slot[i])
        );
    end

    assign full = &busy_vec;  // dispatch while full is dropped

    // scan down so the lowest free index wins
    always_comb begin
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
    end

    // first ready slot at or after rr_ptr with wrap
    always_comb begin
        int pos;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int k = 0; k < RS_DEPTH; k++) begin
            pos = int'(rr_ptr) + k;
            if (pos >= RS_DEPTH) begin
                pos = pos - RS_DEPTH;
            end
            if (!pick_valid && ready_vec[pos]) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(pos);
            end
        end
    end

    // operands still waiting on a live broadcast come straight off the cdb
    always_comb begin
        sel_pkt = slot[pick_idx];
        if (fwd[pick_idx] == CDB_TAG || fwd[pick_idx] == CDB_CDB) begin
            sel_pkt.src1 = cdb.value;
        end
        if (fwd[pick_idx] == TAG_CDB || fwd[pick_idx] == CDB_CDB) begin
            sel_pkt.src2 = cdb.value;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
            rr_ptr      <= '0;
        end else if (squash) begin
            issue_valid <= 1'b0;   // drops the issue register
        end else begin
            issue_valid <= pick_valid;
            if (pick_valid) begin
                rr_ptr <= (pick_idx == IDX_W'(RS_DEPTH - 1)) ? '0 : pick_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pick_valid) begin
            issue_pkt <= sel_pkt;
        end
    end

    // entries leave one at a time unless squashed
    a_one_clear: assert property (@(posedge clock) disable iff (!arst_n)
        !$past(squash) |-> $onehot0($past(busy_vec) & ~busy_vec))
        else $error("rs_station: more than one slot cleared");

    a_no_disp_full: assert property (@(posedge clock) disable iff (!arst_n)
        disp_valid |-> !full)
        else $error("rs_station: dispatch while full, dropped");

endmodule

// ==== rs_entry.sv ====
`timescale 1ns/1ps

module rs_entry (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 squash,
    input  logic                 wr_en,     // from allocator, only when free
    input  logic                 clear,     // from issue picker
    input  rs_types_pkg::disp_t  disp_pkt,
    input  rs_types_pkg::cdb_t   cdb,
    output logic                 busy,
    output logic                 ready,
    output rs_types_pkg::fwd_e   fwd,
    output rs_types_pkg::issue_t slot      // held values, station patches cdb ones
);
    import rs_types_pkg::*;
    import rs_ops_pkg::*;

    // control state
    logic  busy_d;
    tag_t  tag1_q, tag1_d;
    tag_t  tag2_q, tag2_d;

    // payload
    alu_op_e  op_q, op_d;
    word_t    src1_q, src1_d;
    word_t    src2_q, src2_d;
    tag_idx_t dest_q, dest_d;

    logic hit1, hit2;  // held tag sees its producer on the cdb now
    logic ok1, ok2;

    assign hit1 = busy && cdb_hit(tag1_q, cdb);
    assign hit2 = busy && cdb_hit(tag2_q, cdb);

    always_comb begin
        busy_d = busy;
        if (wr_en) begin
            busy_d = 1'b1;
        end else if (clear) begin
            busy_d = 1'b0;
        end
    end

    // operand capture, same wake-up rule on write and while waiting
    always_comb begin
        op_d   = op_q;
        dest_d = dest_q;
        tag1_d = tag1_q;
        tag2_d = tag2_q;
        src1_d = src1_q;
        src2_d = src2_q;
        if (wr_en) begin
            op_d   = disp_pkt.op;
            dest_d = disp_pkt.dest;
            if (cdb_hit(disp_pkt.tag1, cdb)) begin  // producer broadcasting this very cycle
                tag1_d = '0;
                src1_d = cdb.value;
            end else begin
                tag1_d = disp_pkt.tag1;
                src1_d = disp_pkt.src1;
            end
            if (cdb_hit(disp_pkt.tag2, cdb)) begin
                tag2_d = '0;
                src2_d = cdb.value;
            end else begin
                tag2_d = disp_pkt.tag2;
                src2_d = disp_pkt.src2;
            end
        end else begin
            if (hit1) begin
                tag1_d = '0;
                src1_d = cdb.value;
            end
            if (hit2) begin
                tag2_d = '0;
                src2_d = cdb.value;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            tag1_q <= '0;
            tag2_q <= '0;
        end else if (squash) begin
            busy   <= 1'b0;   // stale tags are masked by busy
        end else begin
            busy   <= busy_d;
            tag1_q <= tag1_d;
            tag2_q <= tag2_d;
        end
    end

    always_ff @(posedge clock) begin
        op_q   <= op_d;
        dest_q <= dest_d;
        src1_q <= src1_d;
        src2_q <= src2_d;
    end

    // each operand either present or arriving right now
    assign ok1   = !tag1_q.valid || hit1;
    assign ok2   = !tag2_q.valid || hit2;
    assign ready = busy && ok1 && ok2;

    always_comb begin
        case ({hit1, hit2})
            2'b01:   fwd = TAG_CDB;
            2'b10:   fwd = CDB_TAG;
            2'b11:   fwd = CDB_CDB;
            default: fwd = TAG_TAG;
        endcase
    end

    assign slot = '{op: op_q, src1: src1_q, src2: src2_q, dest: dest_q};

    // allocator must only pick a free slot
    a_wr_free: assert property (@(posedge clock) disable iff (!arst_n)
        wr_en |-> !busy)
        else $error("rs_entry: write into busy slot");

endmodule

// ==== rs_types_pkg.sv ====
package rs_types_pkg;

    localparam int XLEN    = 32;             // datapath width
    localparam int TAG_W   = 4;              // producer tag index width
    localparam int SHAMT_W = $clog2(XLEN);   // shift amount bits taken from src2

    typedef logic [TAG_W-1:0] tag_idx_t;
    typedef logic [XLEN-1:0]  word_t;

    // operand tag, valid set means the value is still outstanding
    typedef struct packed {
        logic     valid;
        tag_idx_t idx;
    } tag_t;

    // common data bus, single source (the alu)
    typedef struct packed {
        logic     valid;
        tag_idx_t tag;
        word_t    value;
    } cdb_t;

    // dispatch packet, srcN ignored while tagN.valid is set
    typedef struct packed {
        rs_ops_pkg::alu_op_e op;
        tag_t                tag1;
        tag_t                tag2;
        word_t               src1;
        word_t               src2;
        tag_idx_t            dest;   // tag this result is broadcast under
    } disp_t;

    // resolved instruction handed to the alu
    typedef struct packed {
        rs_ops_pkg::alu_op_e op;
        word_t               src1;
        word_t               src2;
        tag_idx_t            dest;
    } issue_t;

    // where each operand comes from on issue: held in the entry or off the cdb
    typedef enum logic [1:0] {
        TAG_TAG = 2'b00,  // both held
        TAG_CDB = 2'b01,  // src2 from cdb
        CDB_TAG = 2'b10,  // src1 from cdb
        CDB_CDB = 2'b11   // both from cdb, same producer
    } fwd_e;

    // outstanding tag matched by a live broadcast
    function automatic logic cdb_hit(tag_t t, cdb_t c);
        return t.valid && c.valid && (t.idx == c.tag);
    endfunction

endpackage

// ==== rs_ops_pkg.sv ====
package rs_ops_pkg;

    localparam int OP_W = 3;  // opcode field width

    // integer ALU operations, no memory or branch work reaches this station
    typedef enum logic [OP_W-1:0] {
        OP_ADD = 3'd0,  // a + b
        OP_SUB = 3'd1,  // a - b
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,  // logical left, low shamt bits of b
        OP_SRL = 3'd6,  // logical right
        OP_SLT = 3'd7   // signed compare, result is 0 or 1
    } alu_op_e;

endpackage
